// ==== verilog/harness_cfg.svh ====
`ifndef HARNESS_CFG_SVH
`define HARNESS_CFG_SVH

// number of user designs behind the pads
`define HARNESS_NUM_DESIGNS 12

// width of a design index, wide enough for the park range 12..15
`define HARNESS_IDX_W 4

// pad width in each direction
`define HARNESS_PAD_W 8

// flops per reset synchronizer
`define HARNESS_SYNC_DEPTH 2

// hold length loaded at reset
`define HARNESS_HOLD_DEFAULT 4

`endif

// ==== verilog/harness_pkg.sv ====
`include "harness_cfg.svh"

package harness_pkg;

    // command opcodes, value 3 decodes as nothing
    typedef enum logic [1:0] {
        OP_NOP      = 2'd0,
        OP_SELECT   = 2'd1,
        OP_SET_HOLD = 2'd2
    } cmd_op_t;

    // select view of the command word
    typedef struct packed {
        cmd_op_t                   op;
        logic [`HARNESS_IDX_W-1:0] idx;
        logic [13-`HARNESS_IDX_W:0] rsvd;
    } cmd_sel_t;

    // hold-length view of the command word
    typedef struct packed {
        cmd_op_t    op;
        logic [5:0] rsvd;
        logic [7:0] len;
    } cmd_hold_t;

    // op sits in the same bits in both views
    typedef union packed {
        cmd_sel_t  sel;
        cmd_hold_t hold;
    } cmd_word_t;

    typedef enum logic [2:0] {
        ST_PARKED = 3'd0,
        ST_HOLD   = 3'd1,
        ST_SYNC   = 3'd2,
        ST_RUN    = 3'd3
    } fsm_state_t;

    // one design's drive toward the pads
    typedef struct packed {
        logic [`HARNESS_PAD_W-1:0] val;
        logic [`HARNESS_PAD_W-1:0] oe;
    } pad_bus_t;

endpackage

// ==== verilog/select_fsm.sv ====
`include "harness_cfg.svh"

module select_fsm (
    input  logic                             clk,
    input  logic                             asyncrst_n,
    input  logic                             cmd_strobe,
    input  harness_pkg::cmd_word_t           cmd,
    input  logic                             timer_done,
    output logic                             timer_start,
    output logic                             hold_wr,
    output logic [7:0]                       hold_len,
    output logic [`HARNESS_NUM_DESIGNS-1:0]  hold_mask,
    output logic [`HARNESS_IDX_W-1:0]        active_idx,
    output logic                             route_en,
    output logic                             busy
);

    harness_pkg::fsm_state_t          state_q;
    harness_pkg::cmd_op_t             op;
    logic [`HARNESS_IDX_W-1:0]        idx_q;
    logic [`HARNESS_NUM_DESIGNS-1:0]  mask_q;
    logic [1:0]                       sync_cnt_q;
    logic                             accept_sel;
    logic                             idx_valid;

    // op field is shared by both views of the union
    assign op = cmd.sel.op;

    // commands only count while idle
    assign accept_sel = cmd_strobe && !busy && (op == harness_pkg::OP_SELECT);
    assign hold_wr    = cmd_strobe && !busy && (op == harness_pkg::OP_SET_HOLD);
    assign hold_len   = cmd.hold.len;

    assign timer_start = accept_sel;
    assign idx_valid   = (idx_q < `HARNESS_NUM_DESIGNS);

    assign busy       = (state_q == harness_pkg::ST_HOLD) || (state_q == harness_pkg::ST_SYNC);
    assign route_en   = (state_q == harness_pkg::ST_RUN);
    assign hold_mask  = mask_q;
    assign active_idx = idx_q;

    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            state_q    <= harness_pkg::ST_PARKED;
            idx_q      <= '1;
            mask_q     <= '1;
            sync_cnt_q <= '0;
        end else begin
            case (state_q)
                harness_pkg::ST_PARKED, harness_pkg::ST_RUN: begin
                    if (accept_sel) begin
                        state_q <= harness_pkg::ST_HOLD;
                        idx_q   <= cmd.sel.idx;
                        mask_q  <= '1;
                    end
                end
                harness_pkg::ST_HOLD: begin
                    if (timer_done) begin
                        if (idx_valid) begin
                            // let the new design's synchronizer start releasing
                            state_q    <= harness_pkg::ST_SYNC;
                            mask_q     <= ~({{(`HARNESS_NUM_DESIGNS-1){1'b0}}, 1'b1} << idx_q);
                            sync_cnt_q <= '0;
                        end else begin
                            state_q <= harness_pkg::ST_PARKED;
                        end
                    end
                end
                harness_pkg::ST_SYNC: begin
                    // wait out the synchronizer depth
                    if (sync_cnt_q == 2'(`HARNESS_SYNC_DEPTH - 1)) begin
                        state_q <= harness_pkg::ST_RUN;
                    end
                    sync_cnt_q <= sync_cnt_q + 2'd1;
                end
                default: begin
                    state_q <= harness_pkg::ST_PARKED;
                    mask_q  <= '1;
                end
            endcase
        end
    end

    a_mask_one_low: assert property (@(posedge clk) disable iff (!asyncrst_n)
        $countones(~hold_mask) <= 1);

    // routing only to a design that is out of reset hold
    a_route_unmasked: assert property (@(posedge clk) disable iff (!asyncrst_n)
        route_en |-> !hold_mask[active_idx]);

    // longest hold is 255 plus the sync stage
    a_busy_bounded: assert property (@(posedge clk) disable iff (!asyncrst_n)
        $rose(busy) |-> ##[1:258] !busy);

endmodule

// ==== verilog/hold_timer.sv ====
`include "harness_cfg.svh"

module hold_timer (
    input  logic       clk,
    input  logic       asyncrst_n,
    input  logic       hold_wr,
    input  logic [7:0] hold_len,
    input  logic       timer_start,
    output logic       timer_done
);

    logic [7:0] len_q;
    logic [7:0] cnt_q;

    // stored length, a zero request becomes one
    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            len_q <= 8'(`HARNESS_HOLD_DEFAULT);
        end else if (hold_wr) begin
            len_q <= (hold_len == 8'd0) ? 8'd1 : hold_len;
        end
    end

    // down-counter, zero means idle
    always_ff @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            cnt_q <= '0;
        end else if (timer_start) begin
            cnt_q <= len_q;
        end else if (cnt_q != 8'd0) begin
            cnt_q <= cnt_q - 8'd1;
        end
    end

    // last count of the hold
    assign timer_done = (cnt_q == 8'd1);

    a_done_single: assert property (@(posedge clk) disable iff (!asyncrst_n)
        timer_done |=> !timer_done);

endmodule

// ==== verilog/reset_router.sv ====
`include "harness_cfg.svh"

module reset_router (
    input  logic                            clk,
    input  logic                            asyncrst_n,
    input  logic [`HARNESS_NUM_DESIGNS-1:0] hold_mask,
    output logic [`HARNESS_NUM_DESIGNS-1:0] designs_n_rst
);

    for (genvar g = 0; g < `HARNESS_NUM_DESIGNS; g++) begin : g_design
        logic                           gate_n;
        logic [`HARNESS_SYNC_DEPTH-1:0] sync_q;

        // global reset or a held mask bit pulls this design down
        assign gate_n = asyncrst_n & ~hold_mask[g];

        // asserts at once, releases after the full chain
        always_ff @(posedge clk or negedge gate_n) begin
            if (!gate_n) begin
                sync_q <= '0;
            end else begin
                sync_q <= {sync_q[`HARNESS_SYNC_DEPTH-2:0], 1'b1};
            end
        end

        assign designs_n_rst[g] = sync_q[`HARNESS_SYNC_DEPTH-1];

        a_held_in_reset: assert property (@(posedge clk) disable iff (!asyncrst_n)
            hold_mask[g] |-> !designs_n_rst[g]);
    end

endmodule

// ==== verilog/io_mux.sv ====
`include "harness_cfg.svh"

module io_mux (
    input  logic [`HARNESS_IDX_W-1:0] active_idx,
    input  logic                      route_en,
    input  harness_pkg::pad_bus_t     designs_out [`HARNESS_NUM_DESIGNS],
    input  logic [`HARNESS_PAD_W-1:0] pad_in,
    output harness_pkg::pad_bus_t     pad_out,
    output logic [`HARNESS_PAD_W-1:0] designs_in [`HARNESS_NUM_DESIGNS]
);

    logic route_ok;

    // out-of-range index counts as parked
    assign route_ok = route_en && (active_idx < `HARNESS_NUM_DESIGNS);

    // outbound pads from the active design only
    always_comb begin
        pad_out = '0;
        if (route_ok) begin
            pad_out = designs_out[active_idx];
        end
    end

    // inbound pads steered to one design, zero elsewhere
    always_comb begin
        for (int i = 0; i < `HARNESS_NUM_DESIGNS; i++) begin
            if (route_ok && (active_idx == i)) begin
                designs_in[i] = pad_in;
            end else begin
                designs_in[i] = '0;
            end
        end
    end

endmodule

// ==== verilog/design_harness_top.sv ====
`include "harness_cfg.svh"

module design_harness_top (
    input  logic                            clk,
    input  logic                            asyncrst_n,
    input  logic                            cmd_strobe,
    input  harness_pkg::cmd_word_t          cmd,
    output logic                            busy,
    output logic [`HARNESS_IDX_W-1:0]       active_idx,
    output harness_pkg::pad_bus_t           pad_out,
    input  logic [`HARNESS_PAD_W-1:0]       pad_in,
    input  harness_pkg::pad_bus_t           designs_out [`HARNESS_NUM_DESIGNS],
    output logic [`HARNESS_PAD_W-1:0]       designs_in [`HARNESS_NUM_DESIGNS],
    output logic [`HARNESS_NUM_DESIGNS-1:0] designs_n_rst
);

    logic                            timer_start;
    logic                            timer_done;
    logic                            hold_wr;
    logic [7:0]                      hold_len;
    logic [`HARNESS_NUM_DESIGNS-1:0] hold_mask;
    logic                            route_en;

    select_fsm i_select_fsm (
        .clk         (clk),
        .asyncrst_n  (asyncrst_n),
        .cmd_strobe  (cmd_strobe),
        .cmd         (cmd),
        .timer_done  (timer_done),
        .timer_start (timer_start),
        .hold_wr     (hold_wr),
        .hold_len    (hold_len),
        .hold_mask   (hold_mask),
        .active_idx  (active_idx),
        .route_en    (route_en),
        .busy        (busy)
    );

    hold_timer i_hold_timer (
        .clk         (clk),
        .asyncrst_n  (asyncrst_n),
        .hold_wr     (hold_wr),
        .hold_len    (hold_len),
        .timer_start (timer_start),
        .timer_done  (timer_done)
    );

    reset_router i_reset_router (
        .clk           (clk),
        .asyncrst_n    (asyncrst_n),
        .hold_mask     (hold_mask),
        .designs_n_rst (designs_n_rst)
    );

    io_mux i_io_mux (
        .active_idx  (active_idx),
        .route_en    (route_en),
        .designs_out (designs_out),
        .pad_in      (pad_in),
        .pad_out     (pad_out),
        .designs_in  (designs_in)
    );

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock #(
    parameter int period = 8
) (
    output logic clk
);

    // free-running clock, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

// ==== verification/design_harness_tb.sv ====
`include "harness_cfg.svh"

module design_harness_tb;

    localparam int num_designs     = `HARNESS_NUM_DESIGNS;
    localparam int pad_w           = `HARNESS_PAD_W;
    localparam int reset_cycles    = 4;
    localparam int busy_limit      = 300;
    localparam int random_switches = 26;
    localparam int watchdog_t      = 40 * 270 * 8;

    logic                            clk;
    logic                            asyncrst_n;
    logic                            cmd_strobe;
    harness_pkg::cmd_word_t          cmd;
    logic                            busy;
    logic [`HARNESS_IDX_W-1:0]       active_idx;
    harness_pkg::pad_bus_t           pad_out;
    logic [pad_w-1:0]                pad_in;
    harness_pkg::pad_bus_t           designs_out [num_designs];
    logic [pad_w-1:0]                designs_in [num_designs];
    logic [num_designs-1:0]          designs_n_rst;

    // reference model state
    logic [7:0]                      m_len;
    logic [8:0]                      m_left;
    logic [`HARNESS_IDX_W-1:0]       m_idx;
    logic                            m_run;
    logic                            exp_busy;
    harness_pkg::pad_bus_t           exp_pad_out;
    logic [num_designs-1:0]          exp_n_rst;
    logic [num_designs*pad_w-1:0]    exp_din;
    logic [num_designs*pad_w-1:0]    din_flat;
    logic [31:0]                     lfsr_q;

    tb_clock #(.period(8)) i_clock (.clk(clk));

    design_harness_top i_dut (
        .clk           (clk),
        .asyncrst_n    (asyncrst_n),
        .cmd_strobe    (cmd_strobe),
        .cmd           (cmd),
        .busy          (busy),
        .active_idx    (active_idx),
        .pad_out       (pad_out),
        .pad_in        (pad_in),
        .designs_out   (designs_out),
        .designs_in    (designs_in),
        .designs_n_rst (designs_n_rst)
    );

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "test stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        $display("=== FAIL ===");
        $fatal(1, "test stopped");
    endtask

    // galois form, taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // stand-in for the user designs and the pad pins
    task automatic refresh_pads();
        logic [31:0] r;
        for (int i = 0; i < num_designs; i++) begin
            draw_bits(16, r);
            designs_out[i] = harness_pkg::pad_bus_t'(r[15:0]);
        end
        draw_bits(pad_w, r);
        pad_in = r[pad_w-1:0];
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        refresh_pads();
    endtask

    function automatic harness_pkg::cmd_word_t make_select(input logic [3:0] idx);
        harness_pkg::cmd_word_t w;
        w = '0;
        w.sel.op  = harness_pkg::OP_SELECT;
        w.sel.idx = idx;
        return w;
    endfunction

    function automatic harness_pkg::cmd_word_t make_set_hold(input logic [7:0] len);
        harness_pkg::cmd_word_t w;
        w = '0;
        w.hold.op  = harness_pkg::OP_SET_HOLD;
        w.hold.len = len;
        return w;
    endfunction

    function automatic harness_pkg::cmd_word_t make_nop();
        harness_pkg::cmd_word_t w;
        w = '0;
        w.sel.op = harness_pkg::OP_NOP;
        return w;
    endfunction

    task automatic send_cmd(input harness_pkg::cmd_word_t w);
        cmd_strobe = 1'b1;
        cmd = w;
        next_cycle();
        cmd_strobe = 1'b0;
        cmd = '0;
    endtask

    // random strobes while busy must be ignored
    task automatic wait_idle(input bit poke);
        int          cycles;
        logic [31:0] r;
        cycles = 0;
        while (busy && cycles < busy_limit) begin
            cmd_strobe = 1'b0;
            if (poke) begin
                draw_bits(2, r);
                if (r[1:0] == 2'd0) begin
                    draw_bits(16, r);
                    cmd_strobe = 1'b1;
                    cmd = harness_pkg::cmd_word_t'(r[15:0]);
                end
            end
            next_cycle();
            cycles++;
        end
        cmd_strobe = 1'b0;
        cmd = '0;
        if (busy) begin
            stop_with_error("busy did not fall within the allowed number of cycles");
        end
    endtask

    // select with whatever hold length is currently stored
    task automatic switch_to(input logic [3:0] idx, input int dwell);
        send_cmd(make_nop());
        send_cmd(make_select(idx));
        wait_idle(1'b1);
        repeat (dwell) next_cycle();
    endtask

    task automatic do_switch(input logic [7:0] len, input logic [3:0] idx, input int dwell);
        send_cmd(make_set_hold(len));
        switch_to(idx, dwell);
    endtask

    // expected behavior from the command rules
    always @(posedge clk or negedge asyncrst_n) begin
        if (!asyncrst_n) begin
            m_len  <= 8'(`HARNESS_HOLD_DEFAULT);
            m_left <= '0;
            m_idx  <= '1;
            m_run  <= 1'b0;
        end else if (m_left != 9'd0) begin
            m_left <= m_left - 9'd1;
            if (m_left == 9'd1 && m_idx < num_designs) begin
                m_run <= 1'b1;
            end
        end else if (cmd_strobe && cmd.sel.op == harness_pkg::OP_SELECT) begin
            m_idx <= cmd.sel.idx;
            m_run <= 1'b0;
            // valid designs add the synchronizer stage
            if (cmd.sel.idx < num_designs) begin
                m_left <= 9'(m_len) + 9'(`HARNESS_SYNC_DEPTH);
            end else begin
                m_left <= 9'(m_len);
            end
        end else if (cmd_strobe && cmd.hold.op == harness_pkg::OP_SET_HOLD) begin
            m_len <= (cmd.hold.len == 8'd0) ? 8'd1 : cmd.hold.len;
        end
    end

    always_comb begin
        exp_busy    = (m_left != 9'd0);
        exp_pad_out = '0;
        exp_n_rst   = '0;
        exp_din     = '0;
        if (m_run) begin
            exp_pad_out = designs_out[m_idx];
            exp_n_rst[m_idx] = 1'b1;
            exp_din[m_idx*pad_w +: pad_w] = pad_in;
        end
    end

    always_comb begin
        for (int i = 0; i < num_designs; i++) begin
            din_flat[i*pad_w +: pad_w] = designs_in[i];
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !asyncrst_n |-> ({busy, pad_out, designs_n_rst} == '0))
        else report_mismatch("reset outputs {busy,pad_out,designs_n_rst}",
                             $sampled({busy, pad_out, designs_n_rst}), 128'd0);

    a_busy: assert property (@(posedge clk) disable iff (!asyncrst_n)
        busy == exp_busy)
        else report_mismatch("busy", $sampled(busy), $sampled(exp_busy));

    a_active_idx: assert property (@(posedge clk) disable iff (!asyncrst_n)
        active_idx == m_idx)
        else report_mismatch("active_idx", $sampled(active_idx), $sampled(m_idx));

    // only the running design leaves reset
    a_n_rst: assert property (@(posedge clk) disable iff (!asyncrst_n)
        designs_n_rst == exp_n_rst)
        else report_mismatch("designs_n_rst", $sampled(designs_n_rst), $sampled(exp_n_rst));

    a_pad_out: assert property (@(posedge clk) disable iff (!asyncrst_n)
        pad_out == exp_pad_out)
        else report_mismatch("pad_out", $sampled(pad_out), $sampled(exp_pad_out));

    a_designs_in: assert property (@(posedge clk) disable iff (!asyncrst_n)
        din_flat == exp_din)
        else report_mismatch("designs_in", $sampled(din_flat), $sampled(exp_din));

    initial begin
        #(watchdog_t);
        stop_with_error("watchdog expired before the test sequence finished");
    end

    initial begin
        logic [31:0] r;
        logic [7:0]  len;
        logic [3:0]  idx;
        int          dwell;
        lfsr_q     = 32'd91029;
        asyncrst_n = 1'b1;
        cmd_strobe = 1'b0;
        cmd        = '0;
        refresh_pads();
        #1;
        asyncrst_n = 1'b0;
        repeat (reset_cycles) next_cycle();
        asyncrst_n = 1'b1;
        repeat (3) next_cycle();

        // first switch uses the default hold length
        send_cmd(make_select(4'd3));
        wait_idle(1'b0);
        repeat (4) next_cycle();

        do_switch(8'd0, 4'd5, 3);
        do_switch(8'd1, 4'd11, 3);
        do_switch(8'd255, 4'd0, 2);
        // long window again, length kept from before the pokes
        switch_to(4'd12, 2);
        do_switch(8'd7, 4'd12, 2);
        do_switch(8'd2, 4'd15, 2);
        do_switch(8'd3, 4'd8, 4);

        for (int s = 0; s < random_switches; s++) begin
            draw_bits(3, r);
            if (r[2:0] == 3'd0) begin
                len = 8'd0;
            end else begin
                draw_bits(8, r);
                len = r[7:0];
            end
            draw_bits(4, r);
            idx = r[3:0];
            draw_bits(3, r);
            dwell = 1 + int'(r[2:0]);
            draw_bits(2, r);
            // now and then keep the stored length
            if (r[1:0] == 2'd0) begin
                switch_to(idx, dwell);
            end else begin
                do_switch(len, idx, dwell);
            end
        end

        repeat (4) next_cycle();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== design_harness.f ====
+incdir+verilog
verilog/harness_pkg.sv
verilog/select_fsm.sv
verilog/hold_timer.sv
verilog/reset_router.sv
verilog/io_mux.sv
verilog/design_harness_top.sv
verification/tb_clock.sv
verification/design_harness_tb.sv

// ==== Bender.yml ====
package:
  name: design_harness

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/harness_pkg.sv
      - verilog/select_fsm.sv
      - verilog/hold_timer.sv
      - verilog/reset_router.sv
      - verilog/io_mux.sv
      - verilog/design_harness_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_clock.sv
      - verification/design_harness_tb.sv
